// File: Bender.yml
package:
  name: mips_backend

sources:
  - mips_pkg.sv
  - ex_mem.sv
  - data_mem.sv
  - mem_stage.sv
  - mem_wb.sv
  - reg_file.sv
  - backend_top.sv
  - target: test
    files:
      - tb_backend.sv

// File: backend_top.sv
`timescale 1ns/10ps
`default_nettype none

module backend_top #(
    parameter int MEM_WORDS = mips_pkg::DEFAULT_MEM_WORDS
) (
    input  wire logic              sys_clk,
    input  wire logic              rst_n,
    input  wire logic              stall,
    input  wire mips_pkg::ex_mem_t ex_in,
    output mips_pkg::wb_t          wb,
    input  wire logic [4:0]        rd_a_id,
    output logic [31:0]            rd_a_data,
    input  wire logic [4:0]        rd_b_id,
    output logic [31:0]            rd_b_data
);

    import mips_pkg::*;

    ex_mem_t     ex_q;
    logic [31:0] mem_read_data;
    mem_wb_in_t  mem_in;

    assign mem_in = '{instr: ex_q, mem_read_data: mem_read_data};

    ex_mem ex_mem_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .ex_in   (ex_in),
        .ex_q    (ex_q)
    );

    mem_stage #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_stage_i (
        .sys_clk       (sys_clk),
        .stall         (stall),
        .ex_q          (ex_q),
        .mem_read_data (mem_read_data)
    );

    mem_wb mem_wb_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .mem_in  (mem_in),
        .wb      (wb)
    );

    reg_file reg_file_i (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .wb        (wb),
        .rd_a_id   (rd_a_id),
        .rd_a_data (rd_a_data),
        .rd_b_id   (rd_b_id),
        .rd_b_data (rd_b_data)
    );

endmodule

`default_nettype wire

// File: data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS = mips_pkg::DEFAULT_MEM_WORDS
) (
    input  wire logic                         sys_clk,
    input  wire logic [$clog2(MEM_WORDS)-1:0] word_index,
    input  wire logic [3:0]                   byte_en,
    input  wire logic [31:0]                  wdata,
    output logic [31:0]                       rdata
);

    logic [31:0] mem [MEM_WORDS];   // contents survive reset

    always_ff @(posedge sys_clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (byte_en[lane]) begin
                mem[word_index][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

    // async read since load data is registered in MEM/WB
    assign rdata = mem[word_index];

endmodule

`default_nettype wire

// File: ex_mem.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem (
    input  wire logic              sys_clk,
    input  wire logic              rst_n,
    input  wire logic              stall,
    input  wire mips_pkg::ex_mem_t ex_in,
    output mips_pkg::ex_mem_t      ex_q
);

    import mips_pkg::*;

    // the execute stage keeps ex_in steady while stalled,
    // so holding here is enough to keep the two in step
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            ex_q <= EX_BUBBLE;
        end else if (!stall) begin
            ex_q <= ex_in;
        end
    end

endmodule

`default_nettype wire

// File: mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage #(
    parameter int MEM_WORDS = mips_pkg::DEFAULT_MEM_WORDS
) (
    input  wire logic              sys_clk,
    input  wire logic              stall,
    input  wire mips_pkg::ex_mem_t ex_q,
    output logic [31:0]            mem_read_data
);

    import mips_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [IDX_W-1:0] word_index;
    logic [1:0]       byte_off;
    logic [3:0]       byte_en;
    logic [31:0]      wdata;

    // word address wraps with the memory depth
    assign word_index = ex_q.ex_result[2 +: IDX_W];
    assign byte_off   = ex_q.ex_result[1:0];

    // replicate the store data so every lane sees it
    always_comb begin
        case (ex_q.opcode)
            OP_SB:   wdata = {4{ex_q.store_data[7:0]}};
            OP_SH:   wdata = {2{ex_q.store_data[15:0]}};
            default: wdata = ex_q.store_data;
        endcase
    end

    always_comb begin
        byte_en = 4'b0000;
        if (!stall) begin   // one write per store on the edge that moves it on
            case (ex_q.opcode)
                OP_SB:   byte_en = 4'b0001 << byte_off;
                OP_SH:   byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
                OP_SW:   byte_en = 4'b1111;
                default: byte_en = 4'b0000;
            endcase
        end
    end

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) data_mem_i (
        .sys_clk    (sys_clk),
        .word_index (word_index),
        .byte_en    (byte_en),
        .wdata      (wdata),
        .rdata      (mem_read_data)
    );

endmodule

`default_nettype wire

// File: mem_wb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb (
    input  wire logic                 sys_clk,
    input  wire logic                 rst_n,
    input  wire logic                 stall,
    input  wire mips_pkg::mem_wb_in_t mem_in,
    output mips_pkg::wb_t             wb
);

    import mips_pkg::*;

    mem_wb_in_t  mem_q;
    logic        is_load;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ext_data;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            mem_q <= '{instr: EX_BUBBLE, mem_read_data: 32'd0};
        end else if (!stall) begin
            mem_q <= mem_in;
        end
    end

    always_comb begin
        case (mem_q.instr.opcode)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: is_load = 1'b1;
            default:                             is_load = 1'b0;
        endcase
    end

    // lane pick by the low address bits
    assign ld_byte = mem_q.mem_read_data[mem_q.instr.ex_result[1:0]*8 +: 8];
    assign ld_half = mem_q.mem_read_data[mem_q.instr.ex_result[1]*16 +: 16];

    always_comb begin
        case (mem_q.instr.opcode[2:0])
            3'b000:  ext_data = {{24{ld_byte[7]}}, ld_byte};     // lb
            3'b001:  ext_data = {{16{ld_half[15]}}, ld_half};    // lh
            3'b100:  ext_data = {24'd0, ld_byte};                // lbu
            3'b101:  ext_data = {16'd0, ld_half};                // lhu
            default: ext_data = mem_q.mem_read_data;             // lw
        endcase
    end

    // also the forwarding value for earlier stages
    always_comb begin
        wb.reg_write  = mem_q.instr.reg_write;
        wb.reg_dst_id = mem_q.instr.reg_dst_id;
        wb.reg_wdata  = is_load ? ext_data : mem_q.instr.ex_result;
    end

endmodule

`default_nettype wire

// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    // primary opcodes in standard MIPS encodings
    // low three bits of a load give width and signedness
    typedef enum logic [5:0] {
        OP_ALU = 6'b000000,     // special opcode with a register result only
        OP_LB  = 6'b100000,
        OP_LH  = 6'b100001,
        OP_LW  = 6'b100011,
        OP_LBU = 6'b100100,
        OP_LHU = 6'b100101,
        OP_SB  = 6'b101000,
        OP_SH  = 6'b101001,
        OP_SW  = 6'b101011
    } opcode_e;

    // one instruction leaving execute
    typedef struct packed {
        opcode_e     opcode;
        logic [31:0] ex_result;     // alu result or effective address
        logic [31:0] store_data;
        logic        reg_write;
        logic [4:0]  reg_dst_id;
    } ex_mem_t;

    // MEM/WB input with the word read for the instruction
    typedef struct packed {
        ex_mem_t     instr;
        logic [31:0] mem_read_data;
    } mem_wb_in_t;

    // write-back that doubles as the forwarding value
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  reg_dst_id;
        logic [31:0] reg_wdata;
    } wb_t;

    localparam int DEFAULT_MEM_WORDS = 256;

    // empty slot in the pipe
    localparam ex_mem_t EX_BUBBLE = '{
        opcode:     OP_ALU,
        ex_result:  32'd0,
        store_data: 32'd0,
        reg_write:  1'b0,
        reg_dst_id: 5'd0
    };

endpackage

`default_nettype wire

// File: project.f
mips_pkg.sv
ex_mem.sv
data_mem.sv
mem_stage.sv
mem_wb.sv
reg_file.sv
backend_top.sv
tb_backend.sv

// File: reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic          sys_clk,
    input  wire logic          rst_n,
    input  wire mips_pkg::wb_t wb,
    input  wire logic [4:0]    rd_a_id,
    output logic [31:0]        rd_a_data,
    input  wire logic [4:0]    rd_b_id,
    output logic [31:0]        rd_b_data
);

    import mips_pkg::*;

    logic [31:0] regs [32];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            regs <= '{default: 32'd0};
        end else if (wb.reg_write && (wb.reg_dst_id != 5'd0)) begin
            regs[wb.reg_dst_id] <= wb.reg_wdata;
        end
    end

    // r0 reads zero and a pending write-back wins over the array
    function automatic logic [31:0] read_port(input logic [4:0] id);
        logic [31:0] data;
        if (id == 5'd0) begin
            data = 32'd0;
        end else if (wb.reg_write && (wb.reg_dst_id == id)) begin
            data = wb.reg_wdata;
        end else begin
            data = regs[id];
        end
        return data;
    endfunction

    always_comb begin
        rd_a_data = read_port(rd_a_id);
        rd_b_data = read_port(rd_b_id);
    end

endmodule

`default_nettype wire

// File: tb_backend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_backend;

    import mips_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MEM_WORDS  = 64;
    localparam int IDX_W      = 6;

    // instruction counts per phase for the watchdog
    localparam int N_FILL    = MEM_WORDS;
    localparam int N_ALU     = 32;
    localparam int N_SWLW    = 32;
    localparam int N_SUBWORD = 12;
    localparam int N_EXTEND  = 52;
    localparam int N_STALLED = 40;
    localparam int N_BYPASS  = 8;
    localparam int N_READOUT = MEM_WORDS;
    localparam int N_INSTR   = N_FILL + N_ALU + N_SWLW + N_SUBWORD + N_EXTEND
                             + N_STALLED + N_BYPASS + N_READOUT;
    localparam int STALL_MAX = 3 * N_STALLED;

    logic        sys_clk;
    logic        rst_n;
    logic        stall;
    ex_mem_t     ex_in;
    wb_t         wb;
    logic [4:0]  rd_a_id;
    logic [31:0] rd_a_data;
    logic [4:0]  rd_b_id;
    logic [31:0] rd_b_data;

    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] model_regs [32];
    wb_t         exp_q [$];
    logic [4:0]  dst_hist [2];     // dst of the two previous instructions
    integer      seed = 32'h5687_ac17;

    backend_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut_i (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .ex_in     (ex_in),
        .wb        (wb),
        .rd_a_id   (rd_a_id),
        .rd_a_data (rd_a_data),
        .rd_b_id   (rd_b_id),
        .rd_b_data (rd_b_data)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    task automatic fail_run();
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        fail_run();
    endtask

    // expected reg_wdata from the extraction rules
    function automatic logic [31:0] expected_wdata(input opcode_e op, input logic [31:0] addr,
                                                   input logic [31:0] word,
                                                   input logic [31:0] alu_result);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * addr[1:0]));
        h = 16'(word >> (16 * addr[1]));
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'd0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'd0, h};
            OP_LW:   return word;
            default: return alu_result;
        endcase
    endfunction

    function automatic bit is_store(input opcode_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic logic [31:0] align_addr(input opcode_e op, input logic [31:0] a);
        case (op)
            OP_LH, OP_LHU, OP_SH: return a & ~32'd1;
            OP_LW, OP_SW:         return a & ~32'd3;
            default:              return a;
        endcase
    endfunction

    task automatic store_model(input opcode_e op, input logic [31:0] addr,
                               input logic [31:0] data);
        logic [IDX_W-1:0] idx;
        idx = addr[IDX_W+1:2];
        case (op)
            OP_SB:   model_mem[idx][8*addr[1:0] +: 8] = data[7:0];
            OP_SH:   model_mem[idx][16*addr[1] +: 16] = data[15:0];
            default: model_mem[idx] = data;
        endcase
    endtask

    // drive one instruction and wait until it is accepted
    task automatic issue(input opcode_e op, input logic [31:0] res, input logic [31:0] sdata,
                         input logic wr, input logic [4:0] dst, input bit may_stall);
        wb_t exp;
        int  n;
        ex_in = '{opcode: op, ex_result: res, store_data: sdata, reg_write: wr,
                  reg_dst_id: dst};
        rd_a_id = dst_hist[1];    // on wb during this cycle
        rd_b_id = ($random(seed) & 1) ? dst_hist[1] : 5'($random(seed));
        if (wr) begin
            exp.reg_write  = 1'b1;
            exp.reg_dst_id = dst;
            exp.reg_wdata  = expected_wdata(op, res, model_mem[res[IDX_W+1:2]], res);
            exp_q.push_back(exp);
        end
        if (may_stall && (($random(seed) & 3) == 0)) begin
            n = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
            stall = 1'b1;
            repeat (n) begin
                @(posedge sys_clk);
                #1;
            end
            stall = 1'b0;
        end
        @(posedge sys_clk);
        #1;
        if (is_store(op)) store_model(op, res, sdata);
        dst_hist[1] = dst_hist[0];
        dst_hist[0] = dst;
    endtask

    task automatic check_read_port(input string name, input logic [4:0] id,
                                   input logic [31:0] actual);
        logic [31:0] expected;
        if (id == 5'd0) begin
            expected = 32'd0;
        end else if (wb.reg_write && (exp_q.size() > 0) && (exp_q[0].reg_dst_id == id)) begin
            expected = exp_q[0].reg_wdata;    // bypass of the pending write-back
        end else begin
            expected = model_regs[id];
        end
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    // compares write-backs and read ports at every rising edge
    always @(posedge sys_clk) begin : compare_wb
        wb_t exp;
        if (rst_n) begin
            check_read_port("rd_a_data", rd_a_id, rd_a_data);
            check_read_port("rd_b_data", rd_b_id, rd_b_data);
            if (!stall && wb.reg_write) begin
                assert (exp_q.size() > 0) else begin
                    $display("write-back to r%0d at %0t with no instruction outstanding",
                             wb.reg_dst_id, $time);
                    fail_run();
                end
                exp = exp_q.pop_front();
                assert (wb.reg_dst_id === exp.reg_dst_id)
                    else report_mismatch("wb.reg_dst_id", exp.reg_dst_id, wb.reg_dst_id);
                assert (wb.reg_wdata === exp.reg_wdata)
                    else report_mismatch("wb.reg_wdata", exp.reg_wdata, wb.reg_wdata);
                if (exp.reg_dst_id != 5'd0) model_regs[exp.reg_dst_id] = exp.reg_wdata;
            end
        end
    end

    initial begin : watchdog
        #((N_INSTR + STALL_MAX + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish in the expected time");
        fail_run();
    end

    initial begin : stimulus
        opcode_e          ops [9];
        opcode_e          op;
        logic [31:0]      addr;
        logic [31:0]      addr_list [16];
        logic             wr;
        ops = '{OP_ALU, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
        rst_n   = 1'b0;
        stall   = 1'b0;
        ex_in   = EX_BUBBLE;
        rd_a_id = 5'd0;
        rd_b_id = 5'd0;
        dst_hist = '{default: 5'd0};
        model_regs = '{default: 32'd0};
        repeat (2) @(posedge sys_clk);
        #1;
        rst_n = 1'b1;
        assert (wb.reg_write === 1'b0) else report_mismatch("wb.reg_write", 0, wb.reg_write);

        // fill with a pattern over the whole address
        for (int i = 0; i < N_FILL; i++) begin
            addr = i * 4;
            issue(OP_SW, addr, (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]},
                  1'b0, 5'd0, 1'b0);
        end

        issue(OP_ALU, 32'hdead_beef, 32'd0, 1'b1, 5'd0, 1'b0);   // r0 stays zero
        for (int i = 1; i < N_ALU; i++) begin
            issue(OP_ALU, $random(seed), 32'd0, 1'b1, 5'($random(seed)), 1'b0);
        end

        for (int i = 0; i < 16; i++) begin
            addr_list[i] = align_addr(OP_SW, $random(seed));
            issue(OP_SW, addr_list[i], $random(seed), 1'b0, 5'd0, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            issue(OP_LW, addr_list[i], 32'd0, 1'b1, 5'($random(seed)), 1'b0);
        end

        // sub-word stores at every offset
        for (int off = 0; off < 4; off++) begin
            addr = (40 + off) * 4;
            issue(OP_SB, addr + off, $random(seed), 1'b0, 5'd0, 1'b0);
            issue(OP_LW, addr, 32'd0, 1'b1, 5'($random(seed)), 1'b0);
        end
        for (int h = 0; h < 2; h++) begin
            addr = (44 + h) * 4;
            issue(OP_SH, addr + 2 * h, $random(seed), 1'b0, 5'd0, 1'b0);
            issue(OP_LW, addr, 32'd0, 1'b1, 5'($random(seed)), 1'b0);
        end

        // load extension at every offset
        for (int w = 0; w < 4; w++) begin
            addr = (50 + w) * 4;
            issue(OP_SW, addr, $random(seed), 1'b0, 5'd0, 1'b0);
            for (int off = 0; off < 4; off++) begin
                issue(OP_LB, addr + off, 32'd0, 1'b1, 5'($random(seed)), 1'b0);
                issue(OP_LBU, addr + off, 32'd0, 1'b1, 5'($random(seed)), 1'b0);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue(OP_LH, addr + off, 32'd0, 1'b1, 5'($random(seed)), 1'b0);
                issue(OP_LHU, addr + off, 32'd0, 1'b1, 5'($random(seed)), 1'b0);
            end
        end

        // random mix under random stall
        for (int i = 0; i < N_STALLED; i++) begin
            op   = ops[($random(seed) & 32'h7fff_ffff) % 9];
            addr = align_addr(op, $random(seed));
            wr   = is_store(op) ? 1'b0 : (op != OP_ALU) || (($random(seed) & 7) != 0);
            issue(op, addr, $random(seed), wr, 5'($random(seed)), 1'b1);
        end

        // back-to-back writes to one register read through the bypass
        for (int i = 0; i < N_BYPASS; i++) begin
            issue(OP_ALU, $random(seed), 32'd0, 1'b1, 5'd7, 1'b0);
        end

        for (int i = 0; i < N_READOUT; i++) begin
            issue(OP_LW, i * 4, 32'd0, 1'b1, 5'($random(seed)), 1'b0);
        end

        ex_in = EX_BUBBLE;
        repeat (4) begin
            @(posedge sys_clk);
            #1;
        end
        if (exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d write-backs never appeared on wb", exp_q.size());
            fail_run();
        end
    end

endmodule

`default_nettype wire
